// ==== logic/regfile_pkg.sv ====
// Shared widths, counts and port structs for the register file and writeback subsystem
`default_nettype none

package regfile_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and counts

    // Integer register width
    localparam int XLEN = 32;

    // Architectural registers, x0 included
    localparam int NUM_REGS = 32;

    // Instruction IDs in flight
    localparam int ID_WIDTH = 3;
    localparam int NUM_IDS = 2 ** ID_WIDTH;

    // Source operands per instruction, fixed by the ISA
    localparam int READ_PORTS = 2;

    ////////////////////////////////////////////////////////////
    // Scalar types

    typedef logic [XLEN-1:0] data_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
    typedef logic [ID_WIDTH-1:0] id_t;

    ////////////////////////////////////////////////////////////
    // Port structs

    // One instruction offered at issue
    typedef struct packed {
        logic valid;
        reg_addr_t [READ_PORTS-1:0] rs_addr;
        reg_addr_t rd_addr;
    } issue_t;

    // One result offered by an execution unit
    // Unit holds all fields until it sees ready
    typedef struct packed {
        logic valid;
        id_t id;
        data_t data;
    } wb_t;

endpackage

`default_nettype wire

// ==== logic/register_bank.sv ====
// Register storage bank that the register file instantiates once per commit port
`default_nettype none

module register_bank (
    input wire logic clk,

    // Write side
    input wire regfile_pkg::reg_addr_t rd_addr,
    input wire regfile_pkg::data_t new_data,
    input wire logic commit,

    // Read side with one address per source operand
    input wire regfile_pkg::reg_addr_t [regfile_pkg::READ_PORTS-1:0] read_addr,
    output regfile_pkg::data_t data [regfile_pkg::READ_PORTS]
);

    ////////////////////////////////////////////////////////////
    // Storage

    // Register array indexed by register number
    regfile_pkg::data_t regs [regfile_pkg::NUM_REGS];

    // Single write port
    always_ff @(posedge clk) begin
        if (commit) begin
            regs[rd_addr] <= new_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports

    // x0 always reads zero
    always_comb begin
        for (int r = 0; r < regfile_pkg::READ_PORTS; r++) begin
            if (read_addr[r] == '0) begin
                data[r] = '0;
            end else begin
                data[r] = regs[read_addr[r]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/bank_select_lvt.sv ====
// Live-value table giving, per architectural register, the bank that holds its newest value
`default_nettype none

module bank_select_lvt #(
    parameter int COMMIT_PORTS = 2,
    localparam int SEL_W = (COMMIT_PORTS > 1) ? $clog2(COMMIT_PORTS) : 1
) (
    input wire logic clk,
    input wire logic arst_n,

    // Read lookup, one per source operand
    input wire regfile_pkg::reg_addr_t [regfile_pkg::READ_PORTS-1:0] rs_addr,
    output logic [SEL_W-1:0] rs_sel [regfile_pkg::READ_PORTS],

    // Commit updates, one per commit port
    input wire regfile_pkg::reg_addr_t rd_addr [COMMIT_PORTS],
    input wire logic rd_retired [COMMIT_PORTS]
);

    typedef logic [SEL_W-1:0] bank_sel_t;

    // Bank index per register
    bank_sel_t sel_table [regfile_pkg::NUM_REGS];

    ////////////////////////////////////////////////////////////
    // Table update

    // Every register starts out in bank 0
    // Ports are walked upward so the higher port wins on a shared rd
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int a = 0; a < regfile_pkg::NUM_REGS; a++) begin
                sel_table[a] <= '0;
            end
        end else begin
            for (int p = 0; p < COMMIT_PORTS; p++) begin
                if (rd_retired[p]) begin
                    sel_table[rd_addr[p]] <= bank_sel_t'(p);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Lookup

    // Combinational, same cycle as the issue addresses
    always_comb begin
        for (int r = 0; r < regfile_pkg::READ_PORTS; r++) begin
            rs_sel[r] = sel_table[rs_addr[r]];
        end
    end

endmodule

`default_nettype wire

// ==== logic/rd_id_table.sv ====
// Instruction ID allocator with per-ID destination and per-register latest-writer tables
`default_nettype none

module rd_id_table #(
    parameter int COMMIT_PORTS = 2
) (
    input wire logic clk,
    input wire logic arst_n,

    // Issue side
    input wire regfile_pkg::issue_t issue,
    output logic issue_ready,
    output regfile_pkg::id_t issue_id,

    // Retire side, one entry per commit port
    input wire logic retired [COMMIT_PORTS],
    input wire regfile_pkg::id_t ids_retiring [COMMIT_PORTS],
    output regfile_pkg::reg_addr_t retired_rd_addr [COMMIT_PORTS],
    output regfile_pkg::id_t id_for_rd [COMMIT_PORTS]
);

    ////////////////////////////////////////////////////////////
    // State

    // Next ID in allocation order
    regfile_pkg::id_t next_id;

    // One bit per ID, set from issue until writeback
    logic [regfile_pkg::NUM_IDS-1:0] in_flight;

    // Destination of each ID
    regfile_pkg::reg_addr_t rd_table [regfile_pkg::NUM_IDS];

    // Most recent writer of each register
    regfile_pkg::id_t latest_id [regfile_pkg::NUM_REGS];

    logic issue_accept;

    ////////////////////////////////////////////////////////////
    // Issue handshake

    // Stall while the next ID is still out
    assign issue_ready = ~in_flight[next_id];
    assign issue_id = next_id;
    assign issue_accept = issue.valid & issue_ready;

    // Allocation counter and in-flight bitmap
    // A retiring ID is in flight so it never collides with the one issued
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            next_id <= '0;
            in_flight <= '0;
        end else begin
            for (int p = 0; p < COMMIT_PORTS; p++) begin
                if (retired[p]) begin
                    in_flight[ids_retiring[p]] <= 1'b0;
                end
            end
            if (issue_accept) begin
                in_flight[next_id] <= 1'b1;
                next_id <= next_id + 1'b1;
            end
        end
    end

    // Destination and latest-writer tables
    always_ff @(posedge clk) begin
        if (issue_accept) begin
            rd_table[next_id] <= issue.rd_addr;
            latest_id[issue.rd_addr] <= next_id;
        end
    end

    ////////////////////////////////////////////////////////////
    // Retire lookups

    // Chained lookup, ID to rd to latest writer of that rd
    always_comb begin
        for (int p = 0; p < COMMIT_PORTS; p++) begin
            retired_rd_addr[p] = rd_table[ids_retiring[p]];
            id_for_rd[p] = latest_id[retired_rd_addr[p]];
        end
    end

endmodule

`default_nettype wire

// ==== logic/register_file_and_writeback.sv ====
// Writeback port selection, stale-write filtering, banked register storage and the operand read mux
`default_nettype none

module register_file_and_writeback #(
    parameter int COMMIT_PORTS = 2,
    parameter int NUM_WB_UNITS = 3
) (
    input wire logic clk,
    input wire logic arst_n,

    // Issue side operand read
    input wire regfile_pkg::issue_t issue,
    output regfile_pkg::data_t rs_data [regfile_pkg::READ_PORTS],

    // Execution unit results
    input wire regfile_pkg::wb_t wb [NUM_WB_UNITS],
    output logic wb_ready [NUM_WB_UNITS],

    // ID table retire and lookup
    output logic retired [COMMIT_PORTS],
    output regfile_pkg::id_t ids_retiring [COMMIT_PORTS],
    input wire regfile_pkg::reg_addr_t retired_rd_addr [COMMIT_PORTS],
    input wire regfile_pkg::id_t id_for_rd [COMMIT_PORTS]
);

    localparam int UNIT_W = (NUM_WB_UNITS > 1) ? $clog2(NUM_WB_UNITS) : 1;
    localparam int SEL_W = (COMMIT_PORTS > 1) ? $clog2(COMMIT_PORTS) : 1;

    // Unit granted to each commit port
    logic [UNIT_W-1:0] unit_sel [COMMIT_PORTS];

    // Grant masks used during the priority walk
    logic [NUM_WB_UNITS-1:0] unit_granted;
    logic [COMMIT_PORTS-1:0] port_taken;

    // Result steered onto each commit port
    regfile_pkg::data_t retiring_data [COMMIT_PORTS];

    // Commit enable after the stale-write filter
    logic update_lvt [COMMIT_PORTS];

    // Read data of every bank, then the chosen bank per operand
    regfile_pkg::data_t bank_rdata [COMMIT_PORTS][regfile_pkg::READ_PORTS];
    logic [SEL_W-1:0] rs_sel [regfile_pkg::READ_PORTS];

    ////////////////////////////////////////////////////////////
    // Writeback selection

    // Each port in turn takes the lowest valid unit still free
    // At most COMMIT_PORTS units see ready in one cycle
    always_comb begin
        unit_granted = '0;
        port_taken = '0;
        for (int p = 0; p < COMMIT_PORTS; p++) begin
            unit_sel[p] = '0;
            for (int j = 0; j < NUM_WB_UNITS; j++) begin
                if (wb[j].valid && !unit_granted[j] && !port_taken[p]) begin
                    unit_sel[p] = UNIT_W'(j);
                    unit_granted[j] = 1'b1;
                    port_taken[p] = 1'b1;
                end
            end
        end
    end

    // Handshake outputs
    always_comb begin
        for (int j = 0; j < NUM_WB_UNITS; j++) begin
            wb_ready[j] = unit_granted[j];
        end
    end

    // Port muxes for ID and data
    always_comb begin
        for (int p = 0; p < COMMIT_PORTS; p++) begin
            retired[p] = port_taken[p];
            ids_retiring[p] = wb[unit_sel[p]].id;
            retiring_data[p] = wb[unit_sel[p]].data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stale-write filter

    // Commit only for the latest writer of rd, and never for x0
    // An older result is still accepted so its ID is freed
    always_comb begin
        for (int p = 0; p < COMMIT_PORTS; p++) begin
            update_lvt[p] = retired[p]
                          && (ids_retiring[p] == id_for_rd[p])
                          && (retired_rd_addr[p] != '0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Banks and live-value table

    // One bank per commit port
    for (genvar p = 0; p < COMMIT_PORTS; p++) begin : g_bank
        register_bank u_bank (
            .clk       (clk),
            .rd_addr   (retired_rd_addr[p]),
            .new_data  (retiring_data[p]),
            .commit    (update_lvt[p]),
            .read_addr (issue.rs_addr),
            .data      (bank_rdata[p])
        );
    end

    // Tracks which bank wrote each register last
    bank_select_lvt #(
        .COMMIT_PORTS (COMMIT_PORTS)
    ) u_lvt (
        .clk        (clk),
        .arst_n     (arst_n),
        .rs_addr    (issue.rs_addr),
        .rs_sel     (rs_sel),
        .rd_addr    (retired_rd_addr),
        .rd_retired (update_lvt)
    );

    ////////////////////////////////////////////////////////////
    // Operand read mux

    always_comb begin
        for (int r = 0; r < regfile_pkg::READ_PORTS; r++) begin
            rs_data[r] = bank_rdata[rs_sel[r]][r];
        end
    end

endmodule

`default_nettype wire

// ==== logic/regfile_writeback_top.sv ====
// Top level of the register file and writeback subsystem, joining the ID table to the banked register file
`default_nettype none

module regfile_writeback_top #(
    parameter int COMMIT_PORTS = 2,
    parameter int NUM_WB_UNITS = 3
) (
    input wire logic clk,
    input wire logic arst_n,

    // Issue port
    input wire regfile_pkg::issue_t issue,
    output logic issue_ready,
    output regfile_pkg::id_t issue_id,
    output regfile_pkg::data_t rs_data [regfile_pkg::READ_PORTS],

    // Writeback ports
    input wire regfile_pkg::wb_t wb [NUM_WB_UNITS],
    output logic wb_ready [NUM_WB_UNITS]
);

    // Retire traffic between the two blocks
    logic retired [COMMIT_PORTS];
    regfile_pkg::id_t ids_retiring [COMMIT_PORTS];
    regfile_pkg::reg_addr_t retired_rd_addr [COMMIT_PORTS];
    regfile_pkg::id_t id_for_rd [COMMIT_PORTS];

    ////////////////////////////////////////////////////////////
    // ID allocation and tracking

    rd_id_table #(
        .COMMIT_PORTS (COMMIT_PORTS)
    ) u_id_table (
        .clk             (clk),
        .arst_n          (arst_n),
        .issue           (issue),
        .issue_ready     (issue_ready),
        .issue_id        (issue_id),
        .retired         (retired),
        .ids_retiring    (ids_retiring),
        .retired_rd_addr (retired_rd_addr),
        .id_for_rd       (id_for_rd)
    );

    ////////////////////////////////////////////////////////////
    // Register file and writeback

    register_file_and_writeback #(
        .COMMIT_PORTS (COMMIT_PORTS),
        .NUM_WB_UNITS (NUM_WB_UNITS)
    ) u_rf_wb (
        .clk             (clk),
        .arst_n          (arst_n),
        .issue           (issue),
        .rs_data         (rs_data),
        .wb              (wb),
        .wb_ready        (wb_ready),
        .retired         (retired),
        .ids_retiring    (ids_retiring),
        .retired_rd_addr (retired_rd_addr),
        .id_for_rd       (id_for_rd)
    );

endmodule

`default_nettype wire

// ==== bench/regfile_writeback_tb.sv ====
// Directed testbench for the register file and writeback top level, run from the Makefile
`default_nettype none

module regfile_writeback_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int COMMIT_PORTS = 2;
    localparam int NUM_WB_UNITS = 3;
    localparam int CLK_PERIOD = 100;
    // Tests take about 60 cycles with a wide margin on top
    localparam int WATCHDOG_CYCLES = 400;

    logic clk;
    logic arst_n;
    regfile_pkg::issue_t issue;
    logic issue_ready;
    regfile_pkg::id_t issue_id;
    regfile_pkg::data_t rs_data [regfile_pkg::READ_PORTS];
    regfile_pkg::wb_t wb [NUM_WB_UNITS];
    logic wb_ready [NUM_WB_UNITS];

    ////////////////////////////////////////////////////////////
    // Reference model

    // Expected value and latest issued ID per register
    regfile_pkg::data_t exp_reg [regfile_pkg::NUM_REGS];
    regfile_pkg::id_t writer [regfile_pkg::NUM_REGS];
    // Destination per ID and the IDs still out
    regfile_pkg::reg_addr_t id_dest [regfile_pkg::NUM_IDS];
    logic [regfile_pkg::NUM_IDS-1:0] busy;
    regfile_pkg::id_t next_id_model;

    // What each unit offers on its next writeback
    regfile_pkg::id_t unit_id [NUM_WB_UNITS];
    regfile_pkg::data_t unit_data [NUM_WB_UNITS];

    int checks;
    int errors;

    regfile_writeback_top #(
        .COMMIT_PORTS (COMMIT_PORTS),
        .NUM_WB_UNITS (NUM_WB_UNITS)
    ) DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .issue_ready (issue_ready),
        .issue_id    (issue_id),
        .rs_data     (rs_data),
        .wb          (wb),
        .wb_ready    (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a handshake never completed",
                 WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Lowest valid units first and at most COMMIT_PORTS of them
    function automatic logic [NUM_WB_UNITS-1:0] expected_grant(
        input logic [NUM_WB_UNITS-1:0] valid_units);
        logic [NUM_WB_UNITS-1:0] grant;
        int taken;
        grant = '0;
        taken = 0;
        for (int u = 0; u < NUM_WB_UNITS; u++) begin
            if (valid_units[u] && taken < COMMIT_PORTS) begin
                grant[u] = 1'b1;
                taken++;
            end
        end
        return grant;
    endfunction

    // Frees the ID, commits only the latest writer and never x0
    function automatic void apply_writeback(input int u);
        regfile_pkg::reg_addr_t rd;
        rd = id_dest[unit_id[u]];
        busy[unit_id[u]] = 1'b0;
        if (rd != '0 && writer[rd] == unit_id[u]) begin
            exp_reg[rd] = unit_data[u];
        end
    endfunction

    // All tasks start and end on a falling edge
    task automatic issue_instr(input regfile_pkg::reg_addr_t rd,
                               output regfile_pkg::id_t id);
        logic accepted;
        accepted = 1'b0;
        issue.valid = 1'b1;
        issue.rd_addr = rd;
        issue.rs_addr = '0;
        while (!accepted) begin
            #1;
            compare_value("issue_ready", 32'(issue_ready), 32'(!busy[next_id_model]));
            if (issue_ready) begin
                compare_value("issue_id", 32'(issue_id), 32'(next_id_model));
                id = issue_id;
                accepted = 1'b1;
            end
            @(posedge clk);
            if (accepted) begin
                busy[id] = 1'b1;
                id_dest[id] = rd;
                writer[rd] = id;
                next_id_model = next_id_model + 1'b1;
            end
            @(negedge clk);
        end
        issue.valid = 1'b0;
    endtask

    // Holds each unit's valid until it sees ready
    task automatic write_back(input logic [NUM_WB_UNITS-1:0] units, output int cycles);
        logic [NUM_WB_UNITS-1:0] pending;
        logic [NUM_WB_UNITS-1:0] grant;
        logic [NUM_WB_UNITS-1:0] got;
        pending = units;
        cycles = 0;
        while (pending != '0) begin
            for (int u = 0; u < NUM_WB_UNITS; u++) begin
                wb[u].valid = pending[u];
                wb[u].id = unit_id[u];
                wb[u].data = unit_data[u];
            end
            #1;
            grant = expected_grant(pending);
            for (int u = 0; u < NUM_WB_UNITS; u++) begin
                got[u] = wb_ready[u];
            end
            checks++;
            if (got !== grant) begin
                errors++;
                $display("ERR %0t wb_ready got %b expected %b", $time, got, grant);
            end
            @(posedge clk);
            for (int u = 0; u < NUM_WB_UNITS; u++) begin
                if (pending[u] && got[u]) begin
                    apply_writeback(u);
                end
            end
            pending = pending & ~got;
            cycles++;
            @(negedge clk);
        end
        for (int u = 0; u < NUM_WB_UNITS; u++) begin
            wb[u].valid = 1'b0;
        end
    endtask

    task automatic check_read(input regfile_pkg::reg_addr_t rs0,
                              input regfile_pkg::reg_addr_t rs1);
        issue.valid = 1'b0;
        issue.rs_addr[0] = rs0;
        issue.rs_addr[1] = rs1;
        #1;
        compare_value($sformatf("rs_data[0] x%0d", rs0), rs_data[0], exp_reg[rs0]);
        compare_value($sformatf("rs_data[1] x%0d", rs1), rs_data[1], exp_reg[rs1]);
        @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    // Readback on the cycle right after acceptance
    task automatic basic_write_read();
        int cycles;
        issue_instr(5'd5, unit_id[0]);
        unit_data[0] = $urandom();
        write_back(3'b001, cycles);
        check_read(5'd5, 5'd5);
    endtask

    // Two units in one cycle on separate banks
    task automatic parallel_commit();
        int cycles;
        issue_instr(5'd6, unit_id[0]);
        issue_instr(5'd7, unit_id[1]);
        unit_data[0] = $urandom();
        unit_data[1] = $urandom();
        write_back(3'b011, cycles);
        compare_value("parallel cycles", 32'(cycles), 32'd1);
        check_read(5'd6, 5'd7);
        check_read(5'd7, 5'd6);
    endtask

    // Unit 2 waits one cycle behind units 0 and 1
    task automatic port_limit_priority();
        int cycles;
        issue_instr(5'd11, unit_id[0]);
        issue_instr(5'd12, unit_id[1]);
        issue_instr(5'd13, unit_id[2]);
        for (int u = 0; u < NUM_WB_UNITS; u++) begin
            unit_data[u] = $urandom();
        end
        write_back(3'b111, cycles);
        compare_value("port limit cycles", 32'(cycles), 32'd2);
        check_read(5'd11, 5'd12);
        check_read(5'd13, 5'd11);
    endtask

    // Older result lands last and is dropped
    task automatic stale_write();
        regfile_pkg::id_t id_a;
        regfile_pkg::id_t id_b;
        regfile_pkg::data_t data_a;
        int cycles;
        issue_instr(5'd9, id_a);
        issue_instr(5'd9, id_b);
        data_a = $urandom();
        unit_id[0] = id_b;
        unit_data[0] = $urandom();
        write_back(3'b001, cycles);
        unit_id[0] = id_a;
        unit_data[0] = data_a;
        write_back(3'b001, cycles);
        check_read(5'd9, 5'd9);
    endtask

    task automatic register_zero();
        int cycles;
        issue_instr(5'd0, unit_id[0]);
        unit_data[0] = $urandom();
        write_back(3'b001, cycles);
        compare_value("x0 writeback cycles", 32'(cycles), 32'd1);
        check_read(5'd0, 5'd0);
    endtask

    // Fill all IDs, then free the next one in order
    task automatic issue_back_pressure();
        regfile_pkg::id_t ids [regfile_pkg::NUM_IDS];
        int cycles;
        for (int i = 0; i < regfile_pkg::NUM_IDS; i++) begin
            issue_instr(regfile_pkg::reg_addr_t'(16 + i), ids[i]);
        end
        #1;
        compare_value("issue_ready when full", 32'(issue_ready), 32'd0);
        @(negedge clk);
        unit_id[0] = next_id_model;
        unit_data[0] = $urandom();
        write_back(3'b001, cycles);
        #1;
        compare_value("issue_ready after free", 32'(issue_ready), 32'd1);
        @(negedge clk);
        for (int i = 1; i < regfile_pkg::NUM_IDS; i++) begin
            unit_id[0] = ids[i];
            unit_data[0] = $urandom();
            write_back(3'b001, cycles);
        end
        for (int i = 0; i < regfile_pkg::NUM_IDS; i += 2) begin
            check_read(regfile_pkg::reg_addr_t'(16 + i), regfile_pkg::reg_addr_t'(17 + i));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'hd357c11f));
        checks = 0;
        errors = 0;
        arst_n = 1'b0;
        issue = '0;
        for (int u = 0; u < NUM_WB_UNITS; u++) begin
            wb[u] = '0;
        end
        exp_reg[0] = '0;
        busy = '0;
        next_id_model = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        compare_value("issue_ready after reset", 32'(issue_ready), 32'd1);
        compare_value("issue_id after reset", 32'(issue_id), 32'd0);
        @(negedge clk);

        basic_write_read();
        parallel_commit();
        port_limit_priority();
        stale_write();
        register_zero();
        issue_back_pressure();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/regfile_pkg.sv
logic/register_bank.sv
logic/bank_select_lvt.sv
logic/rd_id_table.sv
logic/register_file_and_writeback.sv
logic/regfile_writeback_top.sv
bench/regfile_writeback_tb.sv

// ==== Makefile ====
# Verilator build and run for the register file and writeback testbench

VERILATOR ?= verilator
TOP       ?= regfile_writeback_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation completed successfully

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
